//--- rtl/byte_bus_pkg.sv
// Byte bus bridge types: opcodes, sequencer phases, request, beat and pin bundles
package byte_bus_pkg;

  localparam int byte_bits  = 8;                        // One beat on the pins
  localparam int word_bytes = 4;                        // Bytes per address and per data word
  localparam int word_bits  = byte_bits * word_bytes;
  localparam int index_bits = $clog2(word_bytes);       // Byte number within a phase

  // Transaction opcode, also the command bit on the pins
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } bus_op_e;

  typedef enum logic [2:0] {
    ph_idle = 3'd0,
    ph_addr = 3'd1,                                     // Address bytes, write data alongside
    ph_cmd  = 3'd2,                                     // Single command beat
    ph_read = 3'd3,                                     // Read bytes gathered from the device
    ph_resp = 3'd4                                      // Waiting for the AXI response to go out
  } phase_e;

  // Held stable by the front end for the whole transaction
  typedef struct packed {
    bus_op_e              op;
    logic [word_bits-1:0] addr;
    logic [word_bits-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    phase_e                phase;
    logic [index_bits-1:0] index;
  } beat_t;

  typedef struct packed {
    logic [byte_bits-1:0] addr_pins;
    logic [byte_bits-1:0] data_out;
    logic                 data_oe;
    logic                 frame;
  } pin_bus_t;

endpackage

//--- rtl/axil_slave_port.sv
// AXI4-Lite slave front end, accepts one transaction at a time and returns its response
`timescale 1ns/100ps

module axil_slave_port (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [31:0]              awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wstrb,       // Ignored, every write is a full word
  input  logic                     wvalid,
  output logic                     wready,
  output logic                     bvalid,
  output logic [1:0]               bresp,
  input  logic                     bready,
  input  logic [31:0]              araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic                     rvalid,
  output logic [31:0]              rdata_out,
  output logic [1:0]               rresp,
  input  logic                     rready,
  output byte_bus_pkg::bus_req_t   req,
  output logic                     start,
  input  logic                     done,
  input  logic [31:0]              rdata
);

  logic busy;                                   // Set from accept until the response is taken
  logic idle;
  logic wr_both_valid;
  logic accept_write;
  logic accept_read;

  assign wr_both_valid = awvalid && wvalid;
  assign idle          = !busy && !awready && !arready;
  assign accept_write  = awready && wr_both_valid;
  assign accept_read   = arready && arvalid;
  assign start         = accept_write || accept_read;

  assign bresp     = 2'b00;                     // Always OKAY
  assign rresp     = 2'b00;
  assign rdata_out = rdata;                     // Gather register holds until the next read

  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      busy    <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= idle && wr_both_valid;         // Write wins when both are offered
      wready  <= idle && wr_both_valid;
      arready <= idle && arvalid && !wr_both_valid;

      if (start)
        busy <= 1'b1;
      else if ((bvalid && bready) || (rvalid && rready))
        busy <= 1'b0;

      if (done && req.op == byte_bus_pkg::op_write)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;

      if (done && req.op == byte_bus_pkg::op_read)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  // Request payload, captured at the accepting handshake
  always_ff @(posedge clk) begin
    if (accept_write)
      req <= '{op: byte_bus_pkg::op_write, addr: awaddr, wdata: wdata};
    else if (accept_read)
      req <= '{op: byte_bus_pkg::op_read, addr: araddr, wdata: '0};
  end

  one_response_a : assert property (@(posedge clk) disable iff (reset)
    !(bvalid && rvalid));

  // Sequencer stays parked in ph_resp while the write response waits
  bvalid_hold_a : assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid && !done);

  // Read word comes from the data lane and must not move while the master stalls
  rvalid_hold_a : assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata_out));

endmodule

//--- rtl/beat_sequencer.sv
// Beat sequencer FSM, frames each transaction and numbers the bytes of every phase
`timescale 1ns/100ps

module beat_sequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  byte_bus_pkg::bus_req_t req,
  input  logic                   start,
  input  logic                   resp_taken,
  output byte_bus_pkg::beat_t    beat,
  output logic                   frame,
  output logic                   done
);

  localparam logic [byte_bus_pkg::index_bits-1:0] last_index =
    byte_bus_pkg::index_bits'(byte_bus_pkg::word_bytes - 1);

  byte_bus_pkg::phase_e                  phase;
  logic [byte_bus_pkg::index_bits-1:0]   index;

  assign beat  = '{phase: phase, index: index};
  assign frame = (phase == byte_bus_pkg::ph_addr) || (phase == byte_bus_pkg::ph_cmd) ||
                 (phase == byte_bus_pkg::ph_read);

  // Last beat of the transaction, response valid follows on the next edge
  assign done = (phase == byte_bus_pkg::ph_cmd && req.op == byte_bus_pkg::op_write) ||
                (phase == byte_bus_pkg::ph_read && index == last_index);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= byte_bus_pkg::ph_idle;
      index <= '0;
    end else begin
      case (phase)
        byte_bus_pkg::ph_idle: begin
          if (start)
            phase <= byte_bus_pkg::ph_addr;
          index <= '0;
        end
        byte_bus_pkg::ph_addr: begin
          if (index == last_index)
            phase <= byte_bus_pkg::ph_cmd;
          index <= index + 1'b1;                // Wraps to zero for the next phase
        end
        byte_bus_pkg::ph_cmd: begin
          if (req.op == byte_bus_pkg::op_write)
            phase <= byte_bus_pkg::ph_resp;
          else
            phase <= byte_bus_pkg::ph_read;
          index <= '0;
        end
        byte_bus_pkg::ph_read: begin
          if (index == last_index)
            phase <= byte_bus_pkg::ph_resp;
          index <= index + 1'b1;
        end
        byte_bus_pkg::ph_resp: begin
          if (resp_taken)
            phase <= byte_bus_pkg::ph_idle;     // Back-pressure holds us here
          index <= '0;
        end
        default: begin
          phase <= byte_bus_pkg::ph_idle;
          index <= '0;
        end
      endcase
    end
  end

  frame_gapless_a : assert property (@(posedge clk) disable iff (reset)
    start |=> (frame throughout done[->1]));

endmodule

//--- rtl/addr_serializer.sv
// Address port driver, puts address bytes and then the command byte on the pins
`timescale 1ns/100ps

module addr_serializer (
  input  byte_bus_pkg::beat_t    beat,
  input  byte_bus_pkg::bus_req_t req,
  output logic [7:0]             addr_pins
);

  always_comb begin
    case (beat.phase)
      byte_bus_pkg::ph_addr:
        addr_pins = req.addr[beat.index * byte_bus_pkg::byte_bits +: byte_bus_pkg::byte_bits];
      byte_bus_pkg::ph_cmd:
        addr_pins = {7'b0, req.op};             // Bit 0 set means write
      default:
        addr_pins = '0;
    endcase
  end

endmodule

//--- rtl/data_lane.sv
// Data lane, drives write bytes with their enable and gathers read bytes into a word
`timescale 1ns/100ps

module data_lane (
  input  logic                   clk,
  input  logic                   reset,
  input  byte_bus_pkg::beat_t    beat,
  input  byte_bus_pkg::bus_req_t req,
  input  logic [7:0]             data_in,
  output logic [7:0]             data_out,
  output logic                   data_oe,
  output logic [31:0]            rdata
);

  logic [byte_bus_pkg::word_bits-1:0] gather;
  logic                               write_beat;

  assign write_beat = (beat.phase == byte_bus_pkg::ph_addr) &&
                      (req.op == byte_bus_pkg::op_write);

  // Write bytes ride alongside the address bytes
  assign data_oe  = write_beat;
  assign data_out = write_beat ?
    req.wdata[beat.index * byte_bus_pkg::byte_bits +: byte_bus_pkg::byte_bits] : '0;

  // LSB arrives first and ends up at the bottom after the fourth shift
  always_ff @(posedge clk) begin
    if (reset)
      gather <= '0;
    else if (beat.phase == byte_bus_pkg::ph_read)
      gather <= {data_in, gather[byte_bus_pkg::word_bits-1:byte_bus_pkg::byte_bits]};
  end

  assign rdata = gather;

  // Write window is four beats from byte 0, then the command beat
  oe_write_window_a : assert property (@(posedge clk) disable iff (reset)
    $rose(data_oe) |-> beat.index == '0 ##1 data_oe [*3] ##1
      !data_oe && beat.phase == byte_bus_pkg::ph_cmd);

endmodule

//--- rtl/byte_bus_bridge.sv
// Byte bus bridge top, AXI4-Lite slave carried one byte per clock to the device port
`timescale 1ns/100ps

module byte_bus_bridge (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [31:0]            awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic                   bvalid,
  output logic [1:0]             bresp,
  input  logic                   bready,
  input  logic [31:0]            araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic                   rvalid,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  input  logic                   rready,
  input  logic [7:0]             data_in,
  output byte_bus_pkg::pin_bus_t pins
);

  byte_bus_pkg::bus_req_t req;
  byte_bus_pkg::beat_t    beat;
  logic                   start;
  logic                   done;
  logic                   frame;
  logic [7:0]             addr_pins;
  logic [7:0]             data_out;
  logic                   data_oe;
  logic [31:0]            lane_rdata;
  wire                    resp_taken = (bvalid && bready) || (rvalid && rready);

  assign pins = '{addr_pins: addr_pins, data_out: data_out, data_oe: data_oe, frame: frame};

  axil_slave_port axil_slave_port_i (
    .clk       (clk),
    .reset     (reset),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bvalid    (bvalid),
    .bresp     (bresp),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rvalid    (rvalid),
    .rdata_out (rdata),
    .rresp     (rresp),
    .rready    (rready),
    .req       (req),
    .start     (start),
    .done      (done),
    .rdata     (lane_rdata)
  );

  beat_sequencer beat_sequencer_i (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .start      (start),
    .resp_taken (resp_taken),
    .beat       (beat),
    .frame      (frame),
    .done       (done)
  );

  addr_serializer addr_serializer_i (
    .beat      (beat),
    .req       (req),
    .addr_pins (addr_pins)
  );

  data_lane data_lane_i (
    .clk      (clk),
    .reset    (reset),
    .beat     (beat),
    .req      (req),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .rdata    (lane_rdata)
  );

endmodule

//--- tests/byte_bus_device_model.sv
// External device model, a 16-word memory behind the byte-serial port
`timescale 1ns/100ps

module byte_bus_device_model (
  input  logic                   clk,
  input  logic                   reset,
  input  byte_bus_pkg::pin_bus_t pins,
  output logic [7:0]             data_in
);

  logic [31:0] mem [16];
  logic [3:0]  beat_cnt;                        // Beats since frame rose
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [1:0]  rd_k;

  initial begin
    for (int i = 0; i < 16; i++)
      mem[i] = 32'h9E37_79B9 * (i + 1);         // Every word differs in every byte
  end

  always @(posedge clk) begin
    if (reset || !pins.frame) begin
      beat_cnt <= '0;
    end else begin
      beat_cnt <= beat_cnt + 1'b1;
      if (beat_cnt < 4) begin
        addr_q[beat_cnt[1:0]*8 +: 8] <= pins.addr_pins;
        if (pins.data_oe)
          wdata_q[beat_cnt[1:0]*8 +: 8] <= pins.data_out;
      end
      if (beat_cnt == 4 && pins.addr_pins[0])
        mem[addr_q[5:2]] <= wdata_q;            // Command beat commits the write
    end
  end

  // Read beats 5 to 8 carry bytes 0 to 3
  assign rd_k    = beat_cnt[1:0] - 2'd1;
  assign data_in = (pins.frame && beat_cnt >= 5) ? mem[addr_q[5:2]][rd_k*8 +: 8] : 8'h00;

endmodule

//--- tests/tb_byte_bus_bridge.sv
// Byte bus bridge testbench, AXI4-Lite stimulus against the device model with assertions
`timescale 1ns/100ps

module tb_byte_bus_bridge;

  localparam int rand_pairs = 20;
  localparam int num_trans  = 10 + 2 * rand_pairs;
  localparam int period     = 4;

  logic clk, reset;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [3:0]  wstrb;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0]  bresp, rresp;
  logic [7:0]  data_in;
  byte_bus_pkg::pin_bus_t pins;

  int          seed = 40577;
  int          errors, tests_run, tests_failed, err_at_start;
  logic [31:0] shadow [16];
  logic [31:0] hs_addr, hs_wdata, word;
  wire         accept_w = awready && awvalid && wvalid;
  wire         accept_r = arready && arvalid;

  byte_bus_bridge byte_bus_bridge_i (.*);
  byte_bus_device_model device_model_i (.clk(clk), .reset(reset), .pins(pins),
                                        .data_in(data_in));

  always #(period / 2) clk = ~clk;

  always @(posedge clk) begin
    if (accept_w) begin
      hs_addr  <= awaddr;
      hs_wdata <= wdata;
    end else if (accept_r) begin
      hs_addr  <= araddr;
    end
  end

  function automatic logic [7:0] byte_of(input logic [31:0] w, input int k);
    return w[k*8 +: 8];
  endfunction

  reset_state_a : assert property (@(posedge clk) $fell(reset) |-> !pins.frame &&
      !pins.data_oe && !bvalid && !rvalid && !awready && !wready && !arready)
    else begin
      errors++;
      $display("CHECK FAILED reset frame=%h data_oe=%h bvalid=%h rvalid=%h", pins.frame,
               pins.data_oe, bvalid, rvalid);
      $display("CHECK FAILED reset awready=%h wready=%h arready=%h", awready, wready,
               arready);
    end

  write_beats_a : assert property (@(posedge clk) disable iff (reset) accept_w |=>
      (pins.frame && pins.data_oe && pins.addr_pins == byte_of(hs_addr, 0) &&
       pins.data_out == byte_of(hs_wdata, 0)) ##1
      (pins.data_oe && pins.addr_pins == byte_of(hs_addr, 1) &&
       pins.data_out == byte_of(hs_wdata, 1)) ##1
      (pins.data_oe && pins.addr_pins == byte_of(hs_addr, 2) &&
       pins.data_out == byte_of(hs_wdata, 2)) ##1
      (pins.data_oe && pins.addr_pins == byte_of(hs_addr, 3) &&
       pins.data_out == byte_of(hs_wdata, 3)) ##1
      (pins.frame && !pins.data_oe && pins.addr_pins == 8'h01) ##1
      ($rose(bvalid) && bresp == 2'b00 && !pins.frame))
    else begin
      errors++;
      $display("CHECK FAILED write beats addr_pins=%h data_out=%h bvalid=%h, addr %h data %h",
               pins.addr_pins, pins.data_out, bvalid, hs_addr, hs_wdata);
    end

  read_beats_a : assert property (@(posedge clk) disable iff (reset) accept_r |=>
      (pins.frame && !pins.data_oe && pins.addr_pins == byte_of(hs_addr, 0)) ##1
      (!pins.data_oe && pins.addr_pins == byte_of(hs_addr, 1)) ##1
      (!pins.data_oe && pins.addr_pins == byte_of(hs_addr, 2)) ##1
      (!pins.data_oe && pins.addr_pins == byte_of(hs_addr, 3)) ##1
      (pins.frame && !pins.data_oe && pins.addr_pins == 8'h00) ##1
      (pins.frame && !pins.data_oe)[*4] ##1
      ($rose(rvalid) && rresp == 2'b00 && rdata == device_model_i.mem[hs_addr[5:2]]))
    else begin
      errors++;
      $display("CHECK FAILED read beats addr_pins=%h rdata=%h, expected word %h",
               pins.addr_pins, rdata, device_model_i.mem[hs_addr[5:2]]);
    end

  resp_stall_a : assert property (@(posedge clk) disable iff (reset)
      (bvalid && !bready) || (rvalid && !rready) |=> !pins.frame && !awready &&
      !wready && !arready && $stable(rdata) && $stable(bresp))
    else begin
      errors++;
      $display("CHECK FAILED stall frame=%h awready=%h arready=%h rdata=%h", pins.frame,
               awready, arready, rdata);
    end

  aw_alone_a : assert property (@(posedge clk) disable iff (reset)
      awvalid && !wvalid |-> !awready && !wready)
    else begin
      errors++;
      $display("Address accepted without write data");
    end

  write_first_a : assert property (@(posedge clk) disable iff (reset)
      $rose(arready) |-> !$past(awvalid && wvalid))
    else begin
      errors++;
      $display("Read accepted while a write was offered");
    end

  task automatic do_write(input logic [31:0] addr, input logic [31:0] data, input int stall);
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'($random(seed));               // Ignored by the bridge
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(negedge clk); while (!awready);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(negedge clk); while (!bvalid);
    repeat (stall) @(negedge clk);
    @(posedge clk) bready <= 1'b1;
    @(posedge clk) bready <= 1'b0;
    shadow[addr[5:2]] = data;
  endtask

  task automatic do_read(input logic [31:0] addr, input int stall);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk) arvalid <= 1'b0;
    do @(negedge clk); while (!rvalid);
    word = rdata;
    shadow_a : assert (word == shadow[addr[5:2]])
      else begin
        errors++;
        $display("CHECK FAILED rdata=%h expected %h", word, shadow[addr[5:2]]);
      end
    repeat (stall) @(negedge clk);
    @(posedge clk) rready <= 1'b1;
    @(posedge clk) rready <= 1'b0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_at_start)
      tests_failed++;
    $display("test %-14s %s", name, (errors != err_at_start) ? "failed" : "ok");
    err_at_start = errors;
  endtask

  initial begin
    #((num_trans * 20 + 4) * period);
    $display("Watchdog expired before the tests finished");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    clk = 0;
    reset = 1;
    {awaddr, wdata, araddr, wstrb} = '0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < 16; i++)
      shadow[i] = device_model_i.mem[i];
    repeat (2) @(posedge clk);
    end_test("reset");
    do_write(32'hC3A5_1E24, 32'h8421_F00D, 0);
    end_test("write");
    do_read(32'h5A6B_7C38, 0);
    end_test("read");
    do_write(32'h0000_0010, $random(seed), 0);
    do_read(32'h0000_0010, 0);
    for (int i = 0; i < rand_pairs; i++) begin
      do_write($random(seed) & 32'h0000_003C, $random(seed), 0);
      do_read($random(seed) & 32'h0000_003C, 0);
    end
    end_test("write_read");
    do_write($random(seed) & 32'h0000_003C, $random(seed), 5);
    do_read($random(seed) & 32'h0000_003C, 5);
    @(posedge clk);
    awaddr  <= 32'h0000_0008;
    awvalid <= 1'b1;                            // Address alone must wait for data
    repeat (6) @(posedge clk);
    do_write(32'h0000_0008, 32'h1234_5678, 0);
    fork
      do_write(32'h0000_002C, 32'hCAFE_0001, 2);
      begin
        @(posedge clk);
        araddr  <= 32'h0000_002C;
        arvalid <= 1'b1;                        // Offered with the write, waits its turn
        do @(negedge clk); while (!awready && !arready);
        first_a : assert (awready)
          else begin
            errors++;
            $display("Read frame started before the offered write");
          end
      end
    join
    fork
      do_read(32'h0000_002C, 2);
      begin
        do @(negedge clk); while (!rvalid);
        do_write(32'h0000_0030, 32'h6D2C_91E7, 0);   // Waits behind the stalled read response
      end
    join
    end_test("backpressure");
    $display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
             errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- flist.f
rtl/byte_bus_pkg.sv
rtl/axil_slave_port.sv
rtl/beat_sequencer.sv
rtl/addr_serializer.sv
rtl/data_lane.sv
rtl/byte_bus_bridge.sv
tests/byte_bus_device_model.sv
tests/tb_byte_bus_bridge.sv
